// ==== hw/csi_rx_pkg.sv ====
package csi_rx_pkg;

	//////////////////////////////////////////////////
	// packet header and word views
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0]  ecc;
		logic [15:0] word_count;
		logic [7:0]  data_id;
	} csi_hdr_t;

	// one fifo word, either a header or raw payload
	typedef union packed {
		csi_hdr_t    hdr;
		logic [31:0] raw;
	} csi_word_u;

	typedef struct packed {
		logic [31:0] data;
		logic [16:0] addr;
	} pixel_t;

	typedef struct packed {
		logic crc_ok;
		logic hdr_fixed;
		logic hdr_err;
		logic frame_start;
	} pkt_status_t;

	localparam logic [5:0]  DT_FRAME_START = 6'h00;
	localparam logic [5:0]  DT_FRAME_END   = 6'h01;
	localparam logic [5:0]  DT_LONG_MIN    = 6'h10;
	localparam logic [7:0]  SYNC_BYTE      = 8'hB8;
	localparam logic [15:0] CRC_INIT       = 16'hFFFF;

	//////////////////////////////////////////////////
	// header ecc and payload crc
	//////////////////////////////////////////////////

	// parity masks per ecc bit, from the csi-2 table
	function automatic logic [5:0] csi_ecc(input logic [23:0] d);
		logic [5:0] p;
		p[0] = ^(d & 24'hF12CB7);
		p[1] = ^(d & 24'hF2555B);
		p[2] = ^(d & 24'h749A6D);
		p[3] = ^(d & 24'hB8E38E);
		p[4] = ^(d & 24'hDF03F0);
		p[5] = ^(d & 24'hEFFC00);
		return p;
	endfunction

	// reflected ccitt, bit 0 of the word goes in first
	function automatic logic [15:0] crc16_word(input logic [15:0] crc, input logic [31:0] data);
		logic [15:0] c;
		c = crc;
		for (int i = 0; i < 32; i++) begin
			if (c[0] ^ data[i]) begin
				c = (c >> 1) ^ 16'h8408;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

endpackage

// ==== hw/lane_aligner.sv ====
`timescale 1ns/1ps

module lane_aligner
	import csi_rx_pkg::*;
(
	input  logic       mipi_clk_2,
	input  logic       reset,
	input  logic       lane_active_i,
	input  logic [3:0] nib_i,
	output logic [7:0] byte_o,
	output logic       byte_valid_o
);

	// bit 0 of hist is the oldest received bit
	logic [11:0] hist;
	logic        locked;
	logic [1:0]  offset;
	logic        phase;
	logic        hit;
	logic [1:0]  hit_off;

	// lowest matching offset wins
	always_comb begin
		hit = 1'b0;
		hit_off = 2'd0;
		for (int k = 3; k >= 0; k--) begin
			if (hist[k +: 8] == SYNC_BYTE) begin
				hit = 1'b1;
				hit_off = 2'(k);
			end
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !lane_active_i) begin
			hist <= '0;
			locked <= 1'b0;
			offset <= 2'd0;
			phase <= 1'b0;
			byte_valid_o <= 1'b0;
		end else begin
			hist <= {nib_i, hist[11:4]};
			byte_valid_o <= 1'b0;
			if (!locked) begin
				if (hit) begin
					locked <= 1'b1;
					offset <= hit_off;
					phase <= 1'b0;
				end
			end else begin
				// a full new byte sits at the offset every second cycle
				phase <= !phase;
				byte_valid_o <= phase;
			end
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (locked && phase) begin
			byte_o <= hist[offset +: 8];
		end
	end

	a_byte_spacing: assert property (@(posedge mipi_clk_2) disable iff (reset)
		byte_valid_o |=> !byte_valid_o)
		else $error("lane_aligner: byte strobes on back-to-back cycles");

endmodule

// ==== hw/word_assembler.sv ====
`timescale 1ns/1ps

module word_assembler
	import csi_rx_pkg::*;
(
	input  logic       mipi_clk_2,
	input  logic       reset,
	input  logic       lane_active_i,
	input  logic [7:0] lane0_byte_i,
	input  logic       lane0_valid_i,
	input  logic [7:0] lane1_byte_i,
	input  logic       lane1_valid_i,
	output csi_word_u  word_o,
	output logic       push_o
);

	// skew holding per lane, one byte deep
	logic [7:0]  hold0, hold1;
	logic        hold0_v, hold1_v;
	logic        pair_ok;
	logic [7:0]  b0, b1;
	logic [15:0] lo_pair;
	logic        half;

	assign pair_ok = (hold0_v || lane0_valid_i) && (hold1_v || lane1_valid_i);
	assign b0 = hold0_v ? hold0 : lane0_byte_i;
	assign b1 = hold1_v ? hold1 : lane1_byte_i;

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !lane_active_i) begin
			hold0_v <= 1'b0;
			hold1_v <= 1'b0;
			half <= 1'b0;
			push_o <= 1'b0;
		end else begin
			// a held byte is replaced when the pair consumes it and a new one lands
			hold0_v <= pair_ok ? (hold0_v && lane0_valid_i) : (hold0_v || lane0_valid_i);
			hold1_v <= pair_ok ? (hold1_v && lane1_valid_i) : (hold1_v || lane1_valid_i);
			if (pair_ok) begin
				half <= !half;
			end
			push_o <= pair_ok && half;
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (lane0_valid_i) begin
			hold0 <= lane0_byte_i;
		end
		if (lane1_valid_i) begin
			hold1 <= lane1_byte_i;
		end
		if (pair_ok && !half) begin
			lo_pair <= {b1, b0};
		end
		if (pair_ok && half) begin
			word_o.raw <= {b1, b0, lo_pair};
		end
	end

	a_no_push_idle: assert property (@(posedge mipi_clk_2) disable iff (reset)
		!lane_active_i |=> !push_o)
		else $error("word_assembler: push outside of a burst");

endmodule

// ==== hw/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo
	import csi_rx_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
) (
	input  logic      mipi_clk_2,
	input  logic      reset,
	input  logic      push_i,
	input  csi_word_u word_i,
	output csi_word_u word_o,
	output logic      valid_o,
	output logic      overflow_o,
	input  logic      ready_i
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	csi_word_u         mem [FIFO_DEPTH];
	logic [AW-1:0]     wr_ptr, rd_ptr;
	logic [CW-1:0]     count;
	logic              full;
	logic              push_ok;
	logic              pop;

	assign full = (count == CW'(FIFO_DEPTH));
	assign push_ok = push_i && !full;
	assign pop = valid_o && ready_i;
	assign valid_o = (count != '0);
	assign word_o = mem[rd_ptr];

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(push_ok) - CW'(pop);
			// lanes cannot stall, a lost word is only flagged
			if (push_i && full) begin
				overflow_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (push_ok) begin
			mem[wr_ptr] <= word_i;
		end
	end

	a_count_range: assert property (@(posedge mipi_clk_2) disable iff (reset)
		count <= CW'(FIFO_DEPTH))
		else $error("word_fifo: occupancy beyond depth");

endmodule

// ==== hw/header_ecc.sv ====
`timescale 1ns/1ps

module header_ecc
	import csi_rx_pkg::*;
(
	input  csi_hdr_t hdr_i,
	output csi_hdr_t hdr_o,
	output logic     fixed_o,
	output logic     err_o
);

	logic [23:0] data_in;
	logic [23:0] data_fixed;
	logic [5:0]  syndrome;
	logic [23:0] flip;
	logic        ecc_only;

	assign data_in = {hdr_i.word_count, hdr_i.data_id};
	assign syndrome = csi_ecc(data_in) ^ hdr_i.ecc[5:0];

	// syndrome equal to a data column points at that bit
	always_comb begin
		flip = '0;
		for (int i = 0; i < 24; i++) begin
			if (syndrome == csi_ecc(24'd1 << i)) begin
				flip[i] = 1'b1;
			end
		end
	end

	// single set bit means the error sits in the ecc byte itself
	assign ecc_only = (syndrome != 6'd0) && ((syndrome & (syndrome - 6'd1)) == 6'd0);

	assign data_fixed = data_in ^ flip;
	assign fixed_o = (flip != '0) || ecc_only;
	assign err_o = (syndrome != 6'd0) && !fixed_o;

	assign hdr_o.ecc = {2'b00, csi_ecc(data_fixed)};
	assign hdr_o.word_count = data_fixed[23:8];
	assign hdr_o.data_id = data_fixed[7:0];

endmodule

// ==== hw/packet_decoder.sv ====
`timescale 1ns/1ps

module packet_decoder
	import csi_rx_pkg::*;
#(
	parameter int FRAME_WORDS = 76800
) (
	input  logic        mipi_clk_2,
	input  logic        reset,
	input  logic        lane_active_i,
	input  csi_word_u   word_i,
	input  logic        word_valid_i,
	output logic        word_ready_o,
	output pixel_t      pixel_o,
	output logic        pixel_valid_o,
	input  logic        pixel_ready_i,
	output pkt_status_t pkt_status_o,
	output logic        pkt_done_o
);

	typedef enum logic [1:0] {ST_HEADER, ST_PAYLOAD, ST_CRC, ST_DISCARD} state_t;

	state_t      state;
	csi_hdr_t    hdr_fix;
	logic        hdr_fixed;
	logic        hdr_err;
	logic [5:0]  dt;
	logic        is_long;
	logic        bad;
	logic        pix_free;
	logic        take;
	logic [13:0] words_left;
	logic [15:0] crc;
	logic [16:0] addr;
	logic        lane_q;

	header_ecc u_header_ecc (
		.hdr_i   (word_i.hdr),
		.hdr_o   (hdr_fix),
		.fixed_o (hdr_fixed),
		.err_o   (hdr_err)
	);

	assign dt = hdr_fix.data_id[5:0];
	assign is_long = (dt >= DT_LONG_MIN);
	assign bad = hdr_err || (is_long && hdr_fix.word_count[1:0] != 2'b00);

	// payload only moves when the pixel register can take it
	assign pix_free = !pixel_valid_o || pixel_ready_i;
	assign word_ready_o = (state == ST_PAYLOAD) ? pix_free : 1'b1;
	assign take = word_valid_i && word_ready_o;

	//////////////////////////////////////////////////
	// packet fsm
	//////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			state <= ST_HEADER;
			pixel_valid_o <= 1'b0;
			pkt_done_o <= 1'b0;
			addr <= '0;
			lane_q <= 1'b0;
		end else begin
			lane_q <= lane_active_i;
			pkt_done_o <= 1'b0;
			if (pixel_valid_o && pixel_ready_i) begin
				pixel_valid_o <= 1'b0;
			end
			case (state)
				ST_HEADER: begin
					if (take) begin
						if (bad) begin
							pkt_done_o <= 1'b1;
							state <= ST_DISCARD;
						end else if (is_long) begin
							state <= (hdr_fix.word_count[15:2] == '0) ? ST_CRC : ST_PAYLOAD;
						end else begin
							pkt_done_o <= 1'b1;
							if (dt == DT_FRAME_START) begin
								addr <= '0;
							end
						end
					end
				end
				ST_PAYLOAD: begin
					if (take) begin
						pixel_valid_o <= 1'b1;
						addr <= (addr == 17'(FRAME_WORDS - 1)) ? '0 : addr + 17'd1;
						if (words_left == 14'd1) begin
							state <= ST_CRC;
						end
					end
				end
				ST_CRC: begin
					if (take) begin
						pkt_done_o <= 1'b1;
						state <= ST_HEADER;
					end
				end
				default: begin
					// low for two cycles so the last in-flight word is dropped too
					if (!lane_active_i && !lane_q) begin
						state <= ST_HEADER;
					end
				end
			endcase
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (state == ST_HEADER && take) begin
			words_left <= hdr_fix.word_count[15:2];
			crc <= CRC_INIT;
			pkt_status_o.crc_ok <= !bad && !is_long;
			pkt_status_o.hdr_fixed <= hdr_fixed;
			pkt_status_o.hdr_err <= bad;
			pkt_status_o.frame_start <= !bad && (dt == DT_FRAME_START);
		end
		if (state == ST_PAYLOAD && take) begin
			pixel_o.data <= word_i.raw;
			pixel_o.addr <= addr;
			crc <= crc16_word(crc, word_i.raw);
			words_left <= words_left - 14'd1;
		end
		if (state == ST_CRC && take) begin
			pkt_status_o.crc_ok <= (word_i.raw[15:0] == crc);
		end
	end

	a_pixel_hold: assert property (@(posedge mipi_clk_2) disable iff (reset)
		pixel_valid_o && !pixel_ready_i |=> pixel_valid_o && $stable(pixel_o))
		else $error("packet_decoder: pixel changed while stalled");

endmodule

// ==== hw/csi_rx_top.sv ====
`timescale 1ns/1ps

module csi_rx_top
	import csi_rx_pkg::*;
#(
	parameter int FIFO_DEPTH  = 8,
	parameter int FRAME_WORDS = 76800
) (
	input  logic        mipi_clk_2,
	input  logic        reset,
	input  logic        lane_active_i,
	input  logic [3:0]  lane0_nib_i,
	input  logic [3:0]  lane1_nib_i,
	input  logic        pixel_ready_i,
	output pixel_t      pixel_o,
	output logic        pixel_valid_o,
	output pkt_status_t pkt_status_o,
	output logic        pkt_done_o,
	output logic        overflow_o
);

	logic [7:0] lane0_byte, lane1_byte;
	logic       lane0_valid, lane1_valid;
	csi_word_u  asm_word, fifo_word;
	logic       asm_push;
	logic       fifo_valid, dec_ready;

	lane_aligner u_lane0 (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.lane_active_i (lane_active_i),
		.nib_i         (lane0_nib_i),
		.byte_o        (lane0_byte),
		.byte_valid_o  (lane0_valid)
	);

	lane_aligner u_lane1 (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.lane_active_i (lane_active_i),
		.nib_i         (lane1_nib_i),
		.byte_o        (lane1_byte),
		.byte_valid_o  (lane1_valid)
	);

	word_assembler u_word_assembler (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.lane_active_i (lane_active_i),
		.lane0_byte_i  (lane0_byte),
		.lane0_valid_i (lane0_valid),
		.lane1_byte_i  (lane1_byte),
		.lane1_valid_i (lane1_valid),
		.word_o        (asm_word),
		.push_o        (asm_push)
	);

	word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_word_fifo (
		.mipi_clk_2 (mipi_clk_2),
		.reset      (reset),
		.push_i     (asm_push),
		.word_i     (asm_word),
		.word_o     (fifo_word),
		.valid_o    (fifo_valid),
		.overflow_o (overflow_o),
		.ready_i    (dec_ready)
	);

	packet_decoder #(
		.FRAME_WORDS (FRAME_WORDS)
	) u_packet_decoder (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.lane_active_i (lane_active_i),
		.word_i        (fifo_word),
		.word_valid_i  (fifo_valid),
		.word_ready_o  (dec_ready),
		.pixel_o       (pixel_o),
		.pixel_valid_o (pixel_valid_o),
		.pixel_ready_i (pixel_ready_i),
		.pkt_status_o  (pkt_status_o),
		.pkt_done_o    (pkt_done_o)
	);

endmodule

// ==== verif/csi_rx_tb.sv ====
`timescale 1ns/1ps

module csi_rx_tb
	import csi_rx_pkg::*;
();

	localparam int FIFO_DEPTH  = 8;
	localparam int FRAME_WORDS = 40;

	logic        mipi_clk_2 = 1'b0;
	logic        reset;
	logic        lane_active_i;
	logic [3:0]  lane0_nib_i, lane1_nib_i;
	logic        pixel_ready_i;
	pixel_t      pixel_o;
	logic        pixel_valid_o;
	pkt_status_t pkt_status_o;
	logic        pkt_done_o;
	logic        overflow_o;

	integer      seed = 32'hd3f6a10d;
	string       test_name = "reset";
	logic [7:0]  pkt_bytes [$];
	pixel_t      exp_q [$];
	pixel_t      exp_pix;
	logic        exp_any = 1'b0;
	int          pix_seen = 0;
	int          done_count = 0;
	int          done_target;
	pkt_status_t exp_status;
	logic [16:0] exp_addr;
	logic        ready_random;
	logic        ready_level;
	logic        overflow_allowed;

	csi_rx_top #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.FRAME_WORDS (FRAME_WORDS)
	) UUT (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.lane_active_i (lane_active_i),
		.lane0_nib_i   (lane0_nib_i),
		.lane1_nib_i   (lane1_nib_i),
		.pixel_ready_i (pixel_ready_i),
		.pixel_o       (pixel_o),
		.pixel_valid_o (pixel_valid_o),
		.pkt_status_o  (pkt_status_o),
		.pkt_done_o    (pkt_done_o),
		.overflow_o    (overflow_o)
	);

	always #4 mipi_clk_2 = ~mipi_clk_2;

	task automatic report_mismatch(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		$display("tests failed");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	// one clock, and the ready line for the next cycle
	task automatic step();
		@(posedge mipi_clk_2);
		if (ready_random) begin
			pixel_ready_i <= (($random(seed) & 3) != 0);
		end else begin
			pixel_ready_i <= ready_level;
		end
	endtask

	function automatic logic [31:0] make_header(input logic [5:0] dt, input logic [15:0] wc);
		logic [23:0] d;
		d = {wc, 2'b00, dt};
		return {2'b00, csi_ecc(d), d};
	endfunction

	task automatic add_word(input logic [31:0] w);
		for (int i = 0; i < 4; i++) begin
			pkt_bytes.push_back(w[8 * i +: 8]);
		end
	endtask

	// lane 0 carries the even bytes, lane 1 the odd ones, lsb first
	function automatic logic [1023:0] lane_stream(input int lane, input int zeros);
		logic [1023:0] s;
		int            pos;
		s = '0;
		pos = zeros;
		s[pos +: 8] = SYNC_BYTE;
		pos += 8;
		for (int j = lane; j < pkt_bytes.size(); j += 2) begin
			s[pos +: 8] = pkt_bytes[j];
			pos += 8;
		end
		return s;
	endfunction

	task automatic send_burst();
		logic [1023:0] s0, s1;
		int            nibs;
		s0 = lane_stream(0, $random(seed) & 3);
		s1 = lane_stream(1, $random(seed) & 3);
		// enough nibbles for the last byte pair to reach the fifo
		nibs = 5 + pkt_bytes.size();
		for (int n = 0; n < nibs; n++) begin
			step();
			lane_active_i <= 1'b1;
			lane0_nib_i <= s0[4 * n +: 4];
			lane1_nib_i <= s1[4 * n +: 4];
		end
		step();
		lane_active_i <= 1'b0;
		lane0_nib_i <= 4'h0;
		lane1_nib_i <= 4'h0;
		repeat (4) begin
			step();
		end
	endtask

	task automatic build_long(input int words, input logic [31:0] hdr_flip, input bit bad_crc,
			input bit record);
		logic [31:0] w;
		logic [15:0] crc;
		pixel_t      p;
		pkt_bytes.delete();
		add_word(make_header(6'h2A, 16'(words * 4)) ^ hdr_flip);
		crc = CRC_INIT;
		for (int i = 0; i < words; i++) begin
			w = $random(seed);
			add_word(w);
			crc = crc16_word(crc, w);
			if (record) begin
				p.data = w;
				p.addr = exp_addr;
				exp_q.push_back(p);
				exp_addr = 17'((exp_addr + 1) % FRAME_WORDS);
			end
		end
		if (bad_crc) begin
			crc = ~crc;
		end
		add_word({16'h0000, crc});
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		done_target++;
		while (done_count < done_target && cycles < 2000) begin
			step();
			cycles++;
		end
		if (done_count < done_target) begin
			report_failure("timed out waiting for pkt_done_o");
		end
		cycles = 0;
		while (pix_seen < exp_q.size() && cycles < 500) begin
			step();
			cycles++;
		end
		if (pix_seen < exp_q.size()) begin
			report_failure("timed out waiting for the expected pixels");
		end
	endtask

	task automatic long_packet(input int words, input logic [31:0] hdr_flip, input bit bad_crc,
			input bit hdr_bad);
		exp_status.crc_ok = !bad_crc && !hdr_bad;
		exp_status.hdr_fixed = (hdr_flip != 32'd0) && !hdr_bad;
		exp_status.hdr_err = hdr_bad;
		exp_status.frame_start = 1'b0;
		build_long(words, hdr_flip, bad_crc, !hdr_bad);
		send_burst();
		wait_done();
	endtask

	task automatic short_packet(input logic [5:0] dt);
		exp_status.crc_ok = 1'b1;
		exp_status.hdr_fixed = 1'b0;
		exp_status.hdr_err = 1'b0;
		exp_status.frame_start = (dt == DT_FRAME_START);
		if (dt == DT_FRAME_START) begin
			exp_addr = '0;
		end
		pkt_bytes.delete();
		add_word(make_header(dt, 16'h0001));
		send_burst();
		wait_done();
	endtask

	//////////////////////////////////////////////////
	// scoreboard and checks
	//////////////////////////////////////////////////

	always @(posedge mipi_clk_2) begin
		if (reset) begin
			done_count <= 0;
			pix_seen <= 0;
		end else begin
			if (pkt_done_o) begin
				done_count <= done_count + 1;
			end
			if (pixel_valid_o && pixel_ready_i) begin
				pix_seen <= pix_seen + 1;
			end
		end
	end

	// expected head refreshed away from the sampling edge
	always @(negedge mipi_clk_2) begin
		exp_any = (pix_seen < exp_q.size());
		if (exp_any) begin
			exp_pix = exp_q[pix_seen];
		end
	end

	a_pixel_expected: assert property (@(posedge mipi_clk_2) disable iff (reset)
		pixel_valid_o && pixel_ready_i |-> exp_any)
		else report_failure("pixel handshake with no pixel expected");

	a_pixel_data: assert property (@(posedge mipi_clk_2) disable iff (reset)
		pixel_valid_o && pixel_ready_i && exp_any |-> pixel_o == exp_pix)
		else report_mismatch("pixel {data, addr}", 64'(exp_pix), 64'($sampled(pixel_o)));

	a_status: assert property (@(posedge mipi_clk_2) disable iff (reset)
		pkt_done_o |-> pkt_status_o == exp_status)
		else report_mismatch("packet status", 64'(exp_status), 64'($sampled(pkt_status_o)));

	a_overflow_low: assert property (@(posedge mipi_clk_2) disable iff (reset)
		!overflow_allowed |-> !overflow_o)
		else report_failure("overflow_o rose while the pixel side kept up");

	a_overflow_sticky: assert property (@(posedge mipi_clk_2) disable iff (reset)
		overflow_o |=> overflow_o)
		else report_failure("overflow_o dropped without a reset");

	initial begin
		int wait_cycles;
		reset = 1'b1;
		lane_active_i = 1'b0;
		lane0_nib_i = 4'h0;
		lane1_nib_i = 4'h0;
		pixel_ready_i = 1'b1;
		ready_random = 1'b0;
		ready_level = 1'b1;
		overflow_allowed = 1'b0;
		exp_addr = '0;
		exp_status = '0;
		done_target = 0;
		repeat (10) begin
			step();
		end
		reset <= 1'b0;

		test_name = "frame start and clean packet";
		short_packet(DT_FRAME_START);
		long_packet(16, 32'd0, 1'b0, 1'b0);

		test_name = "corrupted crc";
		long_packet(8, 32'd0, 1'b1, 1'b0);

		test_name = "single-bit header error";
		long_packet(8, 32'h0000_1000, 1'b0, 1'b0);

		// data_id bit 0 and word_count bit 2
		test_name = "double-bit header error";
		long_packet(8, 32'h0000_0401, 1'b0, 1'b1);
		long_packet(4, 32'd0, 1'b0, 1'b0);

		// addresses wrap at FRAME_WORDS in here
		test_name = "random offsets and ready";
		ready_random = 1'b1;
		for (int k = 0; k < 6; k++) begin
			long_packet(4 + 4 * (k % 3), 32'd0, 1'b0, 1'b0);
		end
		// a new frame restarts the addresses
		short_packet(DT_FRAME_START);
		long_packet(4, 32'd0, 1'b0, 1'b0);
		short_packet(DT_FRAME_END);
		ready_random = 1'b0;

		test_name = "overflow";
		ready_level = 1'b0;
		overflow_allowed = 1'b1;
		build_long(16, 32'd0, 1'b0, 1'b0);
		send_burst();
		wait_cycles = 0;
		while (!overflow_o && wait_cycles < 200) begin
			step();
			wait_cycles++;
		end
		if (!overflow_o) begin
			report_failure("overflow_o never rose with the pixel output stalled");
		end
		repeat (20) begin
			step();
		end
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== all.f ====
hw/csi_rx_pkg.sv
hw/lane_aligner.sv
hw/word_assembler.sv
hw/word_fifo.sv
hw/header_ecc.sv
hw/packet_decoder.sv
hw/csi_rx_top.sv
verif/csi_rx_tb.sv

// ==== Bender.yml ====
package:
  name: csi_rx

sources:
  # rtl in compile order
  - hw/csi_rx_pkg.sv
  - hw/lane_aligner.sv
  - hw/word_assembler.sv
  - hw/word_fifo.sv
  - hw/header_ecc.sv
  - hw/packet_decoder.sv
  - hw/csi_rx_top.sv
  - target: test
    files:
      - verif/csi_rx_tb.sv
